/* axi_ram_top.f */
+incdir+include
rtl/axi_ram_pkg.sv
rtl/burst_addr_gen.sv
rtl/sram_dev.sv
rtl/axi_slv_fsm.sv
rtl/axi_ram_top.sv
bench/tb_axi_ram.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_axi_ram
FILELIST  := axi_ram_top.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_axi_ram.sv */
`timescale 1ns/1ps
`include "axi_ram_cfg.svh"

module tb_axi_ram;
    import axi_ram_pkg::*;

    localparam int    TIMEOUT = 2000;           // Cycles allowed per wait
    localparam addr_t BASE    = `AXI_RAM_BASE;

    logic       i_clk;
    logic       i_nrst;
    logic       aw_valid;
    axi_addr_t  aw_hdr;
    logic       aw_ready;
    logic       w_valid;
    axi_w_t     w_beat;
    logic       w_ready;
    logic       ar_valid;
    axi_addr_t  ar_hdr;
    logic       ar_ready;
    logic       b_valid;
    axi_b_t     b_rsp;
    logic       b_ready;
    logic       r_valid;
    axi_r_t     r_beat;
    logic       r_ready;
    int         n_err;
    int         n_proto;
    int         n_tmo;
    logic       stall_en;                       // Random holds on b_ready and r_ready
    logic       b_open;                         // Write response pending
    logic       rd_open;                        // Read beats pending
    string      test_name;
    data_t      wbuf [256];
    strb_t      sbuf [256];
    logic [7:0] model_mem [4*`AXI_RAM_WORDS];   // Reference RAM, one entry per byte

    axi_ram_top i_dut (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_aw_valid (aw_valid),
        .i_aw       (aw_hdr),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w        (w_beat),
        .o_w_ready  (w_ready),
        .i_ar_valid (ar_valid),
        .i_ar       (ar_hdr),
        .o_ar_ready (ar_ready),
        .o_b_valid  (b_valid),
        .o_b        (b_rsp),
        .i_b_ready  (b_ready),
        .o_r_valid  (r_valid),
        .o_r        (r_beat),
        .i_r_ready  (r_ready)
    );

    always #2 i_clk = ~i_clk;

    // Valid held with a stable payload until the handshake
    assert property (@(posedge i_clk) disable iff (!i_nrst)
        b_valid && !b_ready |=> b_valid && $stable(b_rsp))
    else begin
        n_proto++;
        $display("B channel dropped b_valid or changed its payload before b_ready");
    end

    assert property (@(posedge i_clk) disable iff (!i_nrst)
        r_valid && !r_ready |=> r_valid && $stable(r_beat))
    else begin
        n_proto++;
        $display("R channel dropped r_valid or changed its payload before r_ready");
    end

    assert property (@(posedge i_clk) disable iff (!i_nrst) b_valid |-> b_open)
    else begin
        n_proto++;
        $display("B response raised with no write pending");
    end

    assert property (@(posedge i_clk) disable iff (!i_nrst) r_valid |-> rd_open)
    else begin
        n_proto++;
        $display("R beat raised with no read beat pending");
    end

    // Write has priority, AR is never accepted while AW is offered
    assert property (@(posedge i_clk) disable iff (!i_nrst) aw_valid |-> !ar_ready)
    else begin
        n_proto++;
        $display("AR channel ready while a write address was waiting");
    end

    // AXI beat address for 4-byte beats
    function automatic addr_t burst_beat_addr(input addr_t start, input int len,
                                              input burst_e kind, input int beat);
        addr_t win;
        addr_t lo;
        win = addr_t'(4 * (len + 1));           // Beat size times beat count
        lo  = start & ~(win - addr_t'(1));
        case (kind)
            BURST_FIXED: return start;
            BURST_WRAP:  return lo + (start - lo + addr_t'(4 * beat)) % win;
            default:     return start + addr_t'(4 * beat);
        endcase
    endfunction

    function automatic int word_index(input addr_t a);
        addr_t off;
        off = a - BASE;                         // Below the base wraps high, so out of range
        return int'(off >> 2);
    endfunction

    function automatic data_t model_word(input int idx);
        return {model_mem[4*idx+3], model_mem[4*idx+2], model_mem[4*idx+1], model_mem[4*idx]};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("** Error %s: %s expected %08h, actual %08h", test_name, what, exp, got);
            n_err++;
        end
    endtask

    // Beats come from wbuf and sbuf
    task automatic axi_write(input addr_t start, input int len, input burst_e kind,
                             input id_t tid);
        int    t;
        int    beat;
        int    i;
        int    lane;
        int    idx;
        logic  aw_hs;
        logic  w_hs;
        logic  done;
        resp_t exp_resp;
        beat     = 0;
        done     = 1'b0;
        exp_resp = RESP_OKAY;
        @(negedge i_clk);
        aw_valid = 1'b1;
        aw_hdr   = '{addr: start, len: len_t'(len), size: size_t'(2), burst: kind, id: tid};
        w_valid  = 1'b1;
        w_beat   = '{data: wbuf[0], strb: sbuf[0], last: (len == 0)};
        for (t = 0; t < TIMEOUT && (aw_valid || w_valid); t++) begin
            #1;
            aw_hs = aw_valid & aw_ready;
            w_hs  = w_valid & w_ready;
            @(negedge i_clk);
            if (aw_hs) begin
                aw_valid = 1'b0;
            end
            if (w_hs) begin
                beat++;
                w_valid = (beat <= len);
                if (beat <= len) begin
                    w_beat = '{data: wbuf[beat], strb: sbuf[beat], last: (beat == len)};
                end
            end
        end
        if (aw_valid || w_valid) begin
            $display("Timeout in %s while waiting for the AW and W handshakes", test_name);
            n_tmo++;
            aw_valid = 1'b0;
            w_valid  = 1'b0;
            return;
        end
        for (i = 0; i <= len; i++) begin
            idx = word_index(burst_beat_addr(start, len, kind, i));
            if (idx < `AXI_RAM_WORDS) begin
                for (lane = 0; lane < 4; lane++) begin
                    if (sbuf[i][lane]) begin
                        model_mem[4*idx+lane] = wbuf[i][8*lane +: 8];
                    end
                end
            end else begin
                exp_resp = RESP_SLVERR;         // One bad beat taints the burst
            end
        end
        b_open = 1'b1;
        for (t = 0; t < TIMEOUT && !done; t++) begin
            b_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;
            #1;
            if (b_valid && b_ready) begin
                compare_value("B resp", 32'(exp_resp), 32'(b_rsp.resp));
                compare_value("B id", 32'(tid), 32'(b_rsp.id));
                done = 1'b1;
            end
            @(negedge i_clk);
        end
        b_ready = 1'b0;
        b_open  = 1'b0;
        if (!done) begin
            $display("Timeout in %s while waiting for the write response", test_name);
            n_tmo++;
        end
    endtask

    task automatic axi_read(input addr_t start, input int len, input burst_e kind,
                            input id_t tid);
        int    t;
        int    beat;
        int    idx;
        logic  ar_hs;
        data_t exp_data;
        resp_t exp_resp;
        beat    = 0;
        rd_open = 1'b1;
        @(negedge i_clk);
        ar_valid = 1'b1;
        ar_hdr   = '{addr: start, len: len_t'(len), size: size_t'(2), burst: kind, id: tid};
        for (t = 0; t < TIMEOUT && ar_valid; t++) begin
            #1;
            ar_hs = ar_valid & ar_ready;
            @(negedge i_clk);
            if (ar_hs) begin
                ar_valid = 1'b0;
            end
        end
        if (ar_valid) begin
            $display("Timeout in %s while waiting for the AR handshake", test_name);
            n_tmo++;
            ar_valid = 1'b0;
            rd_open  = 1'b0;
            return;
        end
        for (t = 0; t < TIMEOUT && beat <= len; t++) begin
            r_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;
            #1;
            if (r_valid && r_ready) begin
                idx      = word_index(burst_beat_addr(start, len, kind, beat));
                exp_data = (idx < `AXI_RAM_WORDS) ? model_word(idx) : '0;
                exp_resp = (idx < `AXI_RAM_WORDS) ? RESP_OKAY : RESP_SLVERR;
                compare_value($sformatf("R data beat %0d", beat), exp_data, r_beat.data);
                compare_value($sformatf("R resp beat %0d", beat), 32'(exp_resp),
                              32'(r_beat.resp));
                compare_value($sformatf("R last beat %0d", beat), 32'(beat == len),
                              32'(r_beat.last));
                compare_value("R id", 32'(tid), 32'(r_beat.id));
                beat++;
            end
            @(negedge i_clk);
        end
        r_ready = 1'b0;
        rd_open = 1'b0;
        if (beat <= len) begin
            $display("Timeout in %s while waiting for read beat %0d", test_name, beat);
            n_tmo++;
        end
    endtask

    initial begin
        int    i;
        int    k;
        addr_t a;
        i_clk     = 1'b0;
        i_nrst    = 1'b0;
        aw_valid  = 1'b0;
        aw_hdr    = '0;
        w_valid   = 1'b0;
        w_beat    = '0;
        ar_valid  = 1'b0;
        ar_hdr    = '0;
        b_ready   = 1'b0;
        r_ready   = 1'b0;
        n_err     = 0;
        n_proto   = 0;
        n_tmo     = 0;
        stall_en  = 1'b0;
        b_open    = 1'b0;
        rd_open   = 1'b0;
        test_name = "reset";
        void'($urandom(62));
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        // Idle outputs after reset
        #1;
        compare_value("b_valid", 32'd0, 32'(b_valid));
        compare_value("r_valid", 32'd0, 32'(r_valid));
        compare_value("aw_ready", 32'd1, 32'(aw_ready));
        compare_value("w_ready", 32'd1, 32'(w_ready));
        compare_value("ar_ready", 32'd1, 32'(ar_ready));

        // Known contents everywhere, each word carries its own address
        test_name = "fill";
        for (i = 0; i < `AXI_RAM_WORDS; i++) begin
            wbuf[i] = {16'hC0DE, BASE + addr_t'(4 * i)};
            sbuf[i] = '1;
        end
        axi_write(BASE, `AXI_RAM_WORDS - 1, BURST_INCR, 4'd0);

        test_name = "single_beat";
        wbuf[0] = $urandom;
        sbuf[0] = '1;
        axi_write(BASE + 16'h0020, 0, BURST_INCR, 4'd1);
        axi_read(BASE + 16'h0020, 0, BURST_INCR, 4'd1);

        test_name = "incr_strobe";
        for (i = 0; i < 4; i++) begin
            wbuf[i] = $urandom;
            sbuf[i] = strb_t'($urandom);
        end
        axi_write(BASE + 16'h0040, 3, BURST_INCR, 4'd2);
        axi_read(BASE + 16'h0040, 3, BURST_INCR, 4'd2);

        test_name = "wrap_read";
        axi_read(BASE + 16'h0088, 3, BURST_WRAP, 4'd3);  // Offsets 8, C, 0, 4

        test_name = "fixed_write";
        for (i = 0; i < 3; i++) begin
            wbuf[i] = $urandom;
            sbuf[i] = strb_t'($urandom);
        end
        axi_write(BASE + 16'h00C0, 2, BURST_FIXED, 4'd4);
        axi_read(BASE + 16'h00C0, 0, BURST_INCR, 4'd4);

        test_name = "out_of_range";
        a = BASE + addr_t'(4 * `AXI_RAM_WORDS);
        wbuf[0] = $urandom;
        wbuf[1] = $urandom;
        sbuf[0] = '1;
        sbuf[1] = '1;
        axi_write(a, 0, BURST_INCR, 4'd5);
        axi_read(BASE, 0, BURST_INCR, 4'd5);    // Word 0 is where a truncated index lands
        axi_read(a, 1, BURST_INCR, 4'd5);
        axi_write(a - 16'h0004, 1, BURST_INCR, 4'd6);  // Straddles the top word
        axi_read(a - 16'h0004, 1, BURST_INCR, 4'd6);
        axi_read(BASE - 16'h0004, 0, BURST_INCR, 4'd7);

        test_name = "stall";
        stall_en = 1'b1;
        for (k = 0; k < 6; k++) begin
            for (i = 0; i < 8; i++) begin
                wbuf[i] = $urandom;
                sbuf[i] = strb_t'($urandom);
            end
            a = BASE + addr_t'(4 * ($urandom % 200));
            axi_write(a, 7, BURST_INCR, id_t'(k));
            axi_read(a, 7, BURST_INCR, id_t'(k));
            axi_read(a, 7, BURST_WRAP, id_t'(k + 8));
        end
        stall_en = 1'b0;

        @(negedge i_clk);
        $display("Errors: %0d value, %0d protocol, %0d timeout", n_err, n_proto, n_tmo);
        if (n_err + n_proto + n_tmo == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rtl/axi_ram_top.sv */
`timescale 1ns/1ps

module axi_ram_top (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_aw_valid,
    input  axi_ram_pkg::axi_addr_t i_aw,
    output logic                   o_aw_ready,
    input  logic                   i_w_valid,
    input  axi_ram_pkg::axi_w_t    i_w,
    output logic                   o_w_ready,
    input  logic                   i_ar_valid,
    input  axi_ram_pkg::axi_addr_t i_ar,
    output logic                   o_ar_ready,
    output logic                   o_b_valid,
    output axi_ram_pkg::axi_b_t    o_b,
    input  logic                   i_b_ready,
    output logic                   o_r_valid,
    output axi_ram_pkg::axi_r_t    o_r,
    input  logic                   i_r_ready
);
    import axi_ram_pkg::*;

    logic      load;
    logic      step;
    axi_addr_t hdr;         // Rebased burst header
    addr_t     beat_addr;
    logic      last;
    logic      mem_valid;
    mem_req_t  mem_req;
    logic      mem_resp_valid;
    mem_resp_t mem_resp;

    axi_slv_fsm i_fsm (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_aw_valid       (i_aw_valid),
        .i_aw             (i_aw),
        .o_aw_ready       (o_aw_ready),
        .i_w_valid        (i_w_valid),
        .i_w              (i_w),
        .o_w_ready        (o_w_ready),
        .i_ar_valid       (i_ar_valid),
        .i_ar             (i_ar),
        .o_ar_ready       (o_ar_ready),
        .o_b_valid        (o_b_valid),
        .o_b              (o_b),
        .i_b_ready        (i_b_ready),
        .o_r_valid        (o_r_valid),
        .o_r              (o_r),
        .i_r_ready        (i_r_ready),
        .o_load           (load),
        .o_step           (step),
        .o_hdr            (hdr),
        .i_beat_addr      (beat_addr),
        .i_last           (last),
        .o_mem_valid      (mem_valid),
        .o_mem_req        (mem_req),
        .i_mem_resp_valid (mem_resp_valid),
        .i_mem_resp       (mem_resp)
    );

    burst_addr_gen i_addr_gen (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_load (load),
        .i_step (step),
        .i_hdr  (hdr),
        .o_addr (beat_addr),
        .o_last (last)
    );

    sram_dev i_sram (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (mem_valid),
        .i_req        (mem_req),
        .o_resp_valid (mem_resp_valid),
        .o_resp       (mem_resp)
    );

endmodule

/* rtl/axi_slv_fsm.sv */
`timescale 1ns/1ps
`include "axi_ram_cfg.svh"

module axi_slv_fsm (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_aw_valid,
    input  axi_ram_pkg::axi_addr_t i_aw,
    output logic                   o_aw_ready,
    input  logic                   i_w_valid,
    input  axi_ram_pkg::axi_w_t    i_w,
    output logic                   o_w_ready,
    input  logic                   i_ar_valid,
    input  axi_ram_pkg::axi_addr_t i_ar,
    output logic                   o_ar_ready,
    output logic                   o_b_valid,
    output axi_ram_pkg::axi_b_t    o_b,
    input  logic                   i_b_ready,
    output logic                   o_r_valid,
    output axi_ram_pkg::axi_r_t    o_r,
    input  logic                   i_r_ready,
    output logic                   o_load,
    output logic                   o_step,
    output axi_ram_pkg::axi_addr_t o_hdr,
    input  axi_ram_pkg::addr_t     i_beat_addr,
    input  logic                   i_last,
    output logic                   o_mem_valid,
    output axi_ram_pkg::mem_req_t  o_mem_req,
    input  logic                   i_mem_resp_valid,
    input  axi_ram_pkg::mem_resp_t i_mem_resp
);
    import axi_ram_pkg::*;

    axi_req_state_e state_q, state_d;
    logic   w_held_q;    // W beat taken in IDLE before its AW
    logic   err_q;       // Sticky error over the write burst
    logic   rd_last_q;   // Issued read beat is the final one
    logic   b_valid_q;
    logic   r_valid_q;
    id_t    id_q;
    data_t  wdata_q;
    strb_t  wstrb_q;
    axi_r_t r_q;         // R slot
    logic   w_take;

    assign w_take = i_w_valid & o_w_ready;

    // Header for the address generator, write has priority
    always_comb begin
        o_hdr      = i_aw_valid ? i_aw : i_ar;
        o_hdr.addr = o_hdr.addr - addr_t'(`AXI_RAM_BASE);
    end

    always_comb begin
        state_d     = state_q;
        o_aw_ready  = 1'b0;
        o_w_ready   = 1'b0;
        o_ar_ready  = 1'b0;
        o_load      = 1'b0;
        o_step      = 1'b0;
        o_mem_valid = 1'b0;
        case (state_q)
            IDLE: begin
                o_aw_ready = 1'b1;
                o_w_ready  = ~w_held_q;
                o_ar_ready = ~i_aw_valid & ~w_held_q;
                if (i_aw_valid) begin
                    o_load  = 1'b1;
                    state_d = (w_held_q || i_w_valid) ? WR_BEAT : WR_DATA;
                end else if (i_ar_valid && o_ar_ready) begin
                    o_load  = 1'b1;
                    state_d = RD_ADDR;
                end
            end
            WR_DATA: begin
                o_w_ready = 1'b1;
                if (i_w_valid) begin
                    state_d = WR_BEAT;
                end
            end
            WR_BEAT: begin
                o_mem_valid = 1'b1;       // RAM takes it this cycle
                o_step      = 1'b1;
                o_w_ready   = ~i_last;    // Next beat overlaps the current request
                if (i_last) begin
                    state_d = WR_RESP;
                end else if (!i_w_valid) begin
                    state_d = WR_DATA;
                end
            end
            WR_RESP: begin
                if (b_valid_q && i_b_ready) begin
                    state_d = IDLE;
                end
            end
            RD_ADDR: begin
                // Issue only when the R slot is free by the time data returns
                if (!r_valid_q || i_r_ready) begin
                    o_mem_valid = 1'b1;
                    o_step      = 1'b1;
                    state_d     = RD_DATA;
                end
            end
            RD_DATA: begin
                if (i_mem_resp_valid) begin
                    state_d = rd_last_q ? RD_LAST : RD_ADDR;
                end
            end
            RD_LAST: begin
                if (r_valid_q && i_r_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= IDLE;
            w_held_q  <= 1'b0;
            err_q     <= 1'b0;
            rd_last_q <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                if (i_aw_valid) begin
                    w_held_q <= 1'b0;
                end else if (w_take) begin
                    w_held_q <= 1'b1;
                end
            end
            if (o_load) begin
                err_q <= 1'b0;
            end else if (i_mem_resp_valid && i_mem_resp.err) begin
                err_q <= 1'b1;
            end
            if (state_q == RD_ADDR && o_mem_valid) begin
                rd_last_q <= i_last;
            end
            // Last write response arrives on the first WR_RESP cycle
            if (state_q == WR_RESP) begin
                if (b_valid_q && i_b_ready) begin
                    b_valid_q <= 1'b0;
                end else if (i_mem_resp_valid) begin
                    b_valid_q <= 1'b1;
                end
            end
            if (state_q == RD_DATA && i_mem_resp_valid) begin
                r_valid_q <= 1'b1;
            end else if (i_r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_load) begin
            id_q <= o_hdr.id;
        end
        if (w_take) begin
            wdata_q <= i_w.data;
            wstrb_q <= i_w.strb;
        end
        if (state_q == RD_DATA && i_mem_resp_valid) begin
            r_q.data <= i_mem_resp.rdata;
            r_q.id   <= id_q;
            r_q.resp <= i_mem_resp.err ? RESP_SLVERR : RESP_OKAY;
            r_q.last <= rd_last_q;
        end
    end

    always_comb begin
        o_b.id          = id_q;
        o_b.resp        = err_q ? RESP_SLVERR : RESP_OKAY;
        o_mem_req.addr  = i_beat_addr >> WORD_SHIFT;
        o_mem_req.write = (state_q == WR_BEAT);
        o_mem_req.wdata = wdata_q;
        o_mem_req.wstrb = wstrb_q;
    end

    assign o_b_valid = b_valid_q;
    assign o_r_valid = r_valid_q;
    assign o_r       = r_q;

endmodule

/* rtl/sram_dev.sv */
`timescale 1ns/1ps
`include "axi_ram_cfg.svh"

module sram_dev (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_req_valid,
    input  axi_ram_pkg::mem_req_t  i_req,
    output logic                   o_resp_valid,
    output axi_ram_pkg::mem_resp_t o_resp
);
    import axi_ram_pkg::*;

    localparam int unsigned IDX_BITS = $clog2(`AXI_RAM_WORDS);

    data_t               mem [`AXI_RAM_WORDS];
    data_t               rdata_q;
    logic                err_q;
    logic                valid_q;
    logic                in_range;
    logic [IDX_BITS-1:0] idx;

    assign in_range = (i_req.addr < addr_t'(`AXI_RAM_WORDS));
    assign idx      = i_req.addr[IDX_BITS-1:0];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge i_clk) begin
        if (i_req_valid && in_range && i_req.write) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (i_req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            rdata_q <= in_range ? mem[idx] : '0;  // Old word on a write
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= i_req_valid;
            if (i_req_valid) begin
                err_q <= ~in_range;
            end
        end
    end

    assign o_resp_valid = valid_q;
    assign o_resp.rdata = rdata_q;
    assign o_resp.err   = err_q;

endmodule

/* rtl/burst_addr_gen.sv */
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_load,
    input  logic                   i_step,
    input  axi_ram_pkg::axi_addr_t i_hdr,
    output axi_ram_pkg::addr_t     o_addr,
    output logic                   o_last
);
    import axi_ram_pkg::*;

    addr_t  addr_q;
    addr_t  bytes_q;     // Beat size in bytes
    addr_t  mask_q;      // Wrap window minus one
    burst_e burst_q;
    len_t   cnt_q;       // Beats left after the current one
    addr_t  load_bytes;
    addr_t  addr_incr;
    addr_t  addr_next;

    always_comb begin
        load_bytes = addr_t'(1) << i_hdr.size;
        addr_incr  = addr_q + bytes_q;
        case (burst_q)
            BURST_FIXED: addr_next = addr_q;
            BURST_WRAP:  addr_next = (addr_q & ~mask_q) | (addr_incr & mask_q);
            default:     addr_next = addr_incr;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            addr_q  <= '0;
            bytes_q <= '0;
            mask_q  <= '0;
            burst_q <= BURST_INCR;
            cnt_q   <= '0;
        end else if (i_load) begin
            addr_q  <= i_hdr.addr;
            bytes_q <= load_bytes;
            // Beat count is a power of two for WRAP
            mask_q  <= load_bytes * (addr_t'(i_hdr.len) + addr_t'(1)) - addr_t'(1);
            burst_q <= i_hdr.burst;
            cnt_q   <= i_hdr.len;
        end else if (i_step) begin
            addr_q <= addr_next;
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - len_t'(1);
            end
        end
    end

    assign o_addr = addr_q;
    assign o_last = (cnt_q == '0);

endmodule

/* rtl/axi_ram_pkg.sv */
`include "axi_ram_cfg.svh"

package axi_ram_pkg;

    localparam int unsigned WORD_BYTES = `AXI_RAM_DATA_BITS / 8;
    localparam int unsigned WORD_SHIFT = $clog2(WORD_BYTES);  // Byte offset bits in an address

    typedef logic [`AXI_RAM_ADDR_BITS-1:0] addr_t;
    typedef logic [`AXI_RAM_DATA_BITS-1:0] data_t;
    typedef logic [WORD_BYTES-1:0]         strb_t;
    typedef logic [`AXI_RAM_ID_BITS-1:0]   id_t;
    typedef logic [7:0]                    len_t;   // Beats minus one
    typedef logic [2:0]                    size_t;  // Log2 of bytes per beat
    typedef logic [1:0]                    resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } burst_e;

    typedef enum logic [2:0] {
        IDLE,
        WR_DATA,
        WR_BEAT,
        WR_RESP,
        RD_ADDR,
        RD_DATA,
        RD_LAST
    } axi_req_state_e;

    // AW and AR payload
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_e burst;
        id_t    id;
    } axi_addr_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
    } axi_b_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        resp_t resp;
        logic  last;
    } axi_r_t;

    // One beat towards the RAM, addr is a word index
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t wstrb;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_resp_t;

endpackage

/* include/axi_ram_cfg.svh */
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

// AXI address width in bits
`define AXI_RAM_ADDR_BITS 16

// Data bus width, one RAM word
`define AXI_RAM_DATA_BITS 32

// Transaction ID width
`define AXI_RAM_ID_BITS 4

// RAM depth in words
`define AXI_RAM_WORDS 256

// Start of the slave address window
`define AXI_RAM_BASE 16'h1000

`endif
